// File: files.f
+incdir+common
common/uniboard_pkg.sv
common/protocol_ifs.sv
uart/uart_receiver.sv
uart/uart_transmitter.sv
protocol/frame_receiver.sv
protocol/bus_sequencer.sv
protocol/reply_framer.sv
design/uniboard_bridge_top.sv
tb/tb_uniboard_bridge.sv

// File: Makefile
# Verilator build for the UART command bridge
# Any variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
FILELIST  ?= files.f
TB_TOP    ?= tb_uniboard_bridge
RTL_TOP   ?= uniboard_bridge_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/tb_uniboard_bridge.sv
// Testbench for the UART command bridge with a model of the peripheral bus
// Needs a simulator with timing support, and immediate assertions switched on
`timescale 1ns/10ps
`include "uniboard_defines.svh"

module tb_uniboard_bridge;
	typedef logic [7:0] byte_queue_t [$];

	localparam int BIT_CYCLES = `UNIBOARD_BAUD_DIV;
	localparam int TIMEOUT_CYCLES = 50 * 12 * 10 * `UNIBOARD_BAUD_DIV * 2;
	localparam int REPLY_WAIT_CYCLES = 24 * 10 * BIT_CYCLES;
	localparam int RANDOM_TESTS = 30;

	logic         clk_12MHz;
	logic         reset;
	logic         uart_rx;
	logic         uart_tx;
	logic [7:0]   reg_addr;
	logic         rw;
	logic [127:0] select;
	logic [31:0]  write_data;
	logic [31:0]  read_data;
	logic [2:0]   reg_size;

	// One word per peripheral and register
	logic [31:0]  mem [128][256];
	byte_queue_t  exp_q;
	byte_queue_t  got_q;
	int           errors;
	int           tests_run;
	int           tests_failed;
	int           cycle_count;
	int           write_count;
	int           read_count;
	int           last_write_idx;
	int           last_read_idx;
	logic [7:0]   last_write_addr;
	logic [31:0]  last_write_data;

	uniboard_bridge_top u_uniboard_bridge_top (
		.clk_12MHz  (clk_12MHz),
		.reset      (reset),
		.uart_rx    (uart_rx),
		.uart_tx    (uart_tx),
		.reg_addr   (reg_addr),
		.rw         (rw),
		.select     (select),
		.write_data (write_data),
		.read_data  (read_data),
		.reg_size   (reg_size)
	);

	initial
	begin
		clk_12MHz = 1'b0;
		forever
			#4 clk_12MHz = ~clk_12MHz;
	end

	always @(posedge clk_12MHz)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] fill_word(input int p, input int a);
		return 32'h9E37_79B1 * 32'((p << 8) | a) + 32'h1357_9BDF;
	endfunction

	function automatic logic is_special(input logic [7:0] value);
		return value == `UNIBOARD_START_BYTE || value == `UNIBOARD_END_BYTE
			|| value == `UNIBOARD_ESC_BYTE;
	endfunction

	// Escaped reply frame with the data cut to the register size, at most four bytes
	function automatic byte_queue_t expected_reply(input logic [7:0] header,
		input logic [7:0] addr, input logic [31:0] word, input int size);
		byte_queue_t q;
		logic [7:0]  fields [6];
		fields[0] = header;
		fields[1] = addr;
		for (int i = 0; i < 4; i++)
			fields[i + 2] = word[8 * i +: 8];
		q.push_back(`UNIBOARD_START_BYTE);
		for (int i = 0; i < ((size > 4) ? 4 : size) + 2; i++)
		begin
			if (is_special(fields[i]))
				q.push_back(`UNIBOARD_ESC_BYTE);
			q.push_back(fields[i]);
		end
		q.push_back(`UNIBOARD_END_BYTE);
		return q;
	endfunction

	// Peripheral model, sampled and driven on the falling edge
	initial
	begin : peripheral_model
		logic [127:0] prev_select;
		int           sel_idx;
		read_data   = 32'd0;
		reg_size    = 3'd0;
		prev_select = 128'd0;
		sel_idx     = 0;
		for (int p = 0; p < 128; p++)
			for (int a = 0; a < 256; a++)
				mem[p][a] = fill_word(p, a);
		forever
		begin
			@(negedge clk_12MHz);
			if (select != 128'd0 && prev_select == 128'd0)
			begin
				assert ($onehot(select))
				else
				begin
					$display("FAIL select: got %h, not one-hot", select);
					errors++;
				end
				for (int i = 0; i < 128; i++)
					if (select[i])
						sel_idx = i;
				if (!rw)
				begin
					mem[sel_idx][reg_addr] = write_data;
					write_count++;
					last_write_idx  = sel_idx;
					last_write_addr = reg_addr;
					last_write_data = write_data;
				end
				else
				begin
					read_count++;
					last_read_idx = sel_idx;
				end
			end
			if (select != 128'd0)
			begin
				read_data = mem[sel_idx][reg_addr];
				reg_size  = 3'(sel_idx % 4 + 1);
			end
			else
			begin
				read_data = 32'd0;
				reg_size  = 3'd0;
			end
			prev_select = select;
		end
	end

	// UART monitor, samples each bit of uart_tx in its middle
	initial
	begin : uart_monitor
		logic [7:0] data;
		forever
		begin
			@(negedge clk_12MHz);
			if (uart_tx === 1'b0)
			begin
				repeat (BIT_CYCLES / 2) @(negedge clk_12MHz);
				for (int i = 0; i < 8; i++)
				begin
					repeat (BIT_CYCLES) @(negedge clk_12MHz);
					data[i] = uart_tx;
				end
				repeat (BIT_CYCLES) @(negedge clk_12MHz);
				assert (uart_tx === 1'b1)
				else
				begin
					$display("Reply byte on uart_tx has a low stop bit");
					errors++;
				end
				got_q.push_back(data);
			end
		end
	end

	// Comparison of each monitored byte with the expected reply
	initial
	begin : reply_compare
		logic [7:0] got_byte;
		logic [7:0] exp_byte;
		forever
		begin
			@(negedge clk_12MHz);
			if (got_q.size() > 0)
			begin
				got_byte = got_q.pop_front();
				assert (exp_q.size() > 0)
				else
				begin
					$display("Reply byte %h arrived while no reply was expected", got_byte);
					errors++;
				end
				if (exp_q.size() > 0)
				begin
					exp_byte = exp_q.pop_front();
					assert (got_byte == exp_byte)
					else
					begin
						$display("FAIL uart_tx reply byte: got %h expected %h", got_byte, exp_byte);
						errors++;
					end
				end
			end
		end
	end

	task automatic send_uart_byte(input logic [7:0] value);
		logic [9:0] bits;
		bits = {1'b1, value, 1'b0};
		for (int i = 0; i < 10; i++)
		begin
			uart_rx = bits[i];
			repeat (BIT_CYCLES) @(negedge clk_12MHz);
		end
	endtask

	task automatic send_data_byte(input logic [7:0] value);
		if (is_special(value))
			send_uart_byte(`UNIBOARD_ESC_BYTE);
		send_uart_byte(value);
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before)
			$display("Test %-14s passed", name);
		else
		begin
			tests_failed++;
			$display("Test %-14s failed with %0d errors", name, errors - errors_before);
		end
	endtask

	// Sends one command, waits for its reply and checks the bus activity
	task automatic run_command(input string name, input logic read, input logic [6:0] index,
		input logic [7:0] addr, input logic [31:0] wdata, input int nbytes, input bit restart);
		logic [7:0]  header;
		logic [31:0] sent_word;
		int          writes_before;
		int          reads_before;
		int          errors_before;
		int          wait_cycles;
		header    = {read, index};
		sent_word = 32'd0;
		for (int i = 0; i < nbytes; i++)
			sent_word[8 * i +: 8] = wdata[8 * i +: 8];
		exp_q = expected_reply(header, addr, read ? mem[index][addr] : sent_word,
			int'(index) % 4 + 1);
		writes_before = write_count;
		reads_before  = read_count;
		errors_before = errors;
		if (restart)
		begin
			send_uart_byte(`UNIBOARD_START_BYTE);
			send_data_byte(8'h85);
			send_data_byte(8'h44);
			send_data_byte(8'h99);
		end
		send_uart_byte(`UNIBOARD_START_BYTE);
		send_data_byte(header);
		send_data_byte(addr);
		for (int i = 0; i < nbytes; i++)
			send_data_byte(wdata[8 * i +: 8]);
		send_uart_byte(`UNIBOARD_END_BYTE);
		wait_cycles = 0;
		while ((exp_q.size() > 0 || got_q.size() > 0) && wait_cycles < REPLY_WAIT_CYCLES)
		begin
			@(negedge clk_12MHz);
			wait_cycles++;
		end
		assert (exp_q.size() == 0)
		else
		begin
			$display("Reply for %s was incomplete when the wait ran out", name);
			errors++;
			exp_q.delete();
		end
		assert (read_count - reads_before == 1 && last_read_idx == int'(index))
		else
		begin
			$display("Command %s did not give one read select on its peripheral", name);
			errors++;
		end
		if (!read)
		begin
			assert (write_count - writes_before == 1)
			else
			begin
				$display("Write %s gave %0d write selects", name, write_count - writes_before);
				errors++;
			end
			assert (last_write_idx == int'(index))
			else
			begin
				$display("FAIL select index: got %h expected %h", last_write_idx, index);
				errors++;
			end
			assert (last_write_addr == addr)
			else
			begin
				$display("FAIL reg_addr: got %h expected %h", last_write_addr, addr);
				errors++;
			end
			assert (last_write_data == sent_word)
			else
			begin
				$display("FAIL write_data: got %h expected %h", last_write_data, sent_word);
				errors++;
			end
		end
		else
		begin
			assert (write_count == writes_before)
			else
			begin
				$display("Read %s raised select with rw low", name);
				errors++;
			end
		end
		// Leaves time for the bridge to return to idle
		repeat (20 * BIT_CYCLES) @(negedge clk_12MHz);
		report_test(name, errors_before);
	endtask

	// A dropped frame must leave the bus and the UART line quiet
	task automatic expect_silence(input string name, input int writes_before,
		input int reads_before, input int errors_before);
		repeat (40 * BIT_CYCLES) @(negedge clk_12MHz);
		assert (write_count == writes_before && read_count == reads_before)
		else
		begin
			$display("Dropped frame in %s still raised select", name);
			errors++;
		end
		report_test(name, errors_before);
	endtask

	initial
	begin : stimulus
		logic       rd;
		logic [6:0] idx;
		logic [7:0] addr;
		logic [6:0] prev_idx;
		logic [7:0] prev_addr;
		int         nb;
		int         writes_before;
		int         reads_before;
		int         errors_before;
		void'($urandom(32'h4ece7715));
		reset     = 1'b1;
		uart_rx   = 1'b1;
		prev_idx  = 7'h05;
		prev_addr = 8'h20;
		repeat (3) @(posedge clk_12MHz);
		@(negedge clk_12MHz);
		reset = 1'b0;
		repeat (4 * BIT_CYCLES) @(negedge clk_12MHz);

		run_command("write_basic", 1'b0, 7'h05, 8'h20, 32'hCAFE_F00D, 4, 1'b0);
		run_command("read_back", 1'b1, 7'h05, 8'h20, 32'd0, 0, 1'b0);
		run_command("read_fill", 1'b1, 7'h42, 8'h10, 32'd0, 0, 1'b0);
		run_command("write_short", 1'b0, 7'h01, 8'h1B, 32'h0000_A517, 2, 1'b0);
		run_command("escape_write", 1'b0, 7'h1B, 8'h17, 32'h171B_0117, 4, 1'b0);
		run_command("escape_read", 1'b1, 7'h1B, 8'h17, 32'd0, 0, 1'b0);

		writes_before = write_count;
		reads_before  = read_count;
		errors_before = errors;
		send_uart_byte(`UNIBOARD_START_BYTE);
		send_data_byte(8'h03);
		send_uart_byte(`UNIBOARD_END_BYTE);
		expect_silence("short_frame", writes_before, reads_before, errors_before);

		writes_before = write_count;
		reads_before  = read_count;
		errors_before = errors;
		send_data_byte(8'h02);
		send_data_byte(8'h30);
		send_data_byte(8'h44);
		send_uart_byte(`UNIBOARD_END_BYTE);
		expect_silence("no_start", writes_before, reads_before, errors_before);

		run_command("restart", 1'b0, 7'h2A, 8'h3C, 32'h8765_4321, 4, 1'b1);

		for (int n = 0; n < RANDOM_TESTS; n++)
		begin
			rd = 1'($urandom_range(1, 0));
			// About one command in three goes back to the last register so reads see written words
			if ($urandom_range(2, 0) == 0)
			begin
				idx  = prev_idx;
				addr = prev_addr;
			end
			else
			begin
				idx  = 7'($urandom);
				addr = 8'($urandom);
			end
			nb = rd ? 0 : int'($urandom_range(4, 0));
			run_command($sformatf("random_%0d", n), rd, idx, addr, $urandom, nb, 1'b0);
			prev_idx  = idx;
			prev_addr = addr;
		end

		$display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end
endmodule

// File: design/uniboard_bridge_top.sv
// UART command bridge for the rover control board
// External peripherals share reg_addr, rw and write_data and each has its own select
`timescale 1ns/10ps

module uniboard_bridge_top (
	input  logic         clk_12MHz,
	input  logic         reset,
	input  logic         uart_rx,
	output logic         uart_tx,
	output logic [7:0]   reg_addr,
	output logic         rw,
	output logic [127:0] select,
	output logic [31:0]  write_data,
	input  logic [31:0]  read_data,
	input  logic [2:0]   reg_size
);
	logic [7:0] rx_data;
	logic       rx_valid;
	logic [7:0] tx_data;
	logic       send;
	logic       busy;

	command_if u_command_if ();
	reply_if   u_reply_if ();

	uart_receiver u_uart_receiver (
		.clk_12MHz (clk_12MHz),
		.reset     (reset),
		.rx        (uart_rx),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid)
	);

	frame_receiver u_frame_receiver (
		.clk_12MHz (clk_12MHz),
		.reset     (reset),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.cmd       (u_command_if.sender)
	);

	bus_sequencer u_bus_sequencer (
		.clk_12MHz  (clk_12MHz),
		.reset      (reset),
		.cmd        (u_command_if.receiver),
		.reply      (u_reply_if.source),
		.reg_addr   (reg_addr),
		.rw         (rw),
		.select     (select),
		.write_data (write_data),
		.read_data  (read_data),
		.reg_size   (reg_size)
	);

	reply_framer u_reply_framer (
		.clk_12MHz (clk_12MHz),
		.reset     (reset),
		.reply     (u_reply_if.sink),
		.tx_data   (tx_data),
		.send      (send),
		.busy      (busy)
	);

	uart_transmitter u_uart_transmitter (
		.clk_12MHz (clk_12MHz),
		.reset     (reset),
		.tx_data   (tx_data),
		.send      (send),
		.tx        (uart_tx),
		.busy      (busy)
	);
endmodule

// File: protocol/reply_framer.sv
// Sends start, header, address, reply_size data bytes and end
// Reply fields must stay stable from reply_start until reply_done
`timescale 1ns/10ps
`include "uniboard_defines.svh"

module reply_framer (
	input  logic       clk_12MHz,
	input  logic       reset,
	reply_if.sink      reply,
	output logic [7:0] tx_data,
	output logic       send,
	input  logic       busy
);
	typedef enum logic [1:0] {F_IDLE, F_LOAD, F_WAIT_BUSY, F_WAIT_IDLE} framer_state_t;

	framer_state_t state;
	logic [3:0]    byte_index;
	logic [3:0]    data_index;
	logic          escape_sent;
	logic          is_last;
	logic          is_special;
	logic [7:0]    next_byte;

	// Byte order is start, header, address, data LSB first, end
	always_comb
	begin
		is_last    = byte_index == {1'b0, reply.reply_size} + 4'd3;
		data_index = byte_index - 4'd3;
		if (byte_index == 4'd0)
			next_byte = `UNIBOARD_START_BYTE;
		else if (byte_index == 4'd1)
			next_byte = reply.reply_header;
		else if (byte_index == 4'd2)
			next_byte = reply.reply_addr;
		else if (is_last)
			next_byte = `UNIBOARD_END_BYTE;
		else
			next_byte = 8'(reply.reply_data >> {data_index, 3'b000});
		// the markers themselves go out bare
		is_special = byte_index != 4'd0 && !is_last
			&& (next_byte == `UNIBOARD_START_BYTE || next_byte == `UNIBOARD_END_BYTE
			|| next_byte == `UNIBOARD_ESC_BYTE);
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (state == F_LOAD)
			tx_data <= (is_special && !escape_sent) ? `UNIBOARD_ESC_BYTE : next_byte;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state            <= F_IDLE;
			byte_index       <= 4'd0;
			escape_sent      <= 1'b0;
			send             <= 1'b0;
			reply.reply_done <= 1'b0;
		end
		else
		begin
			send             <= 1'b0;
			reply.reply_done <= 1'b0;
			case (state)
				F_IDLE:
					if (reply.reply_start)
					begin
						byte_index  <= 4'd0;
						escape_sent <= 1'b0;
						state       <= F_LOAD;
					end
				F_LOAD:
				begin
					// After an escape the same byte is loaded again, this time bare
					escape_sent <= is_special && !escape_sent;
					send        <= 1'b1;
					state       <= F_WAIT_BUSY;
				end
				F_WAIT_BUSY:
					if (busy)
						state <= F_WAIT_IDLE;
				default:
					if (!busy)
					begin
						if (escape_sent)
							state <= F_LOAD;
						else if (is_last)
						begin
							reply.reply_done <= 1'b1;
							state            <= F_IDLE;
						end
						else
						begin
							byte_index <= byte_index + 4'd1;
							state      <= F_LOAD;
						end
					end
			endcase
		end
	end
endmodule

// File: protocol/bus_sequencer.sv
// Runs one command on the peripheral bus. A write is always read back
// Peripherals must hold read_data and reg_size while select is high
`timescale 1ns/10ps
`include "uniboard_defines.svh"

module bus_sequencer (
	input  logic         clk_12MHz,
	input  logic         reset,
	command_if.receiver  cmd,
	reply_if.source      reply,
	output logic [7:0]   reg_addr,
	output logic         rw,
	output logic [127:0] select,
	output logic [31:0]  write_data,
	input  logic [31:0]  read_data,
	input  logic [2:0]   reg_size
);
	typedef enum logic [2:0] {
		S_IDLE, S_WRITE_SELECT, S_WRITE_HOLD, S_WRITE_GAP,
		S_READ_SELECT, S_READ_HOLD, S_REPLY
	} seq_state_t;

	seq_state_t                state;
	logic [3:0]                cycle_count;
	uniboard_pkg::cmd_header_t header_q;

	assign cmd.bridge_idle    = state == S_IDLE;
	assign reply.reply_header = header_q;
	assign reply.reply_addr   = reg_addr;

	always_ff @(posedge clk_12MHz)
	begin
		if (state == S_IDLE && cmd.cmd_valid)
		begin
			header_q   <= cmd.cmd.header;
			reg_addr   <= cmd.cmd.addr;
			write_data <= cmd.cmd.wdata;
		end
		if (state == S_READ_HOLD && cycle_count == 4'(`UNIBOARD_SELECT_CYCLES))
		begin
			reply.reply_data <= read_data;
			reply.reply_size <= (reg_size > 3'd4) ? 3'd4 : reg_size;
		end
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state             <= S_IDLE;
			cycle_count       <= 4'd0;
			rw                <= 1'b1;
			select            <= 128'd0;
			reply.reply_start <= 1'b0;
		end
		else
		begin
			reply.reply_start <= 1'b0;
			cycle_count       <= cycle_count + 4'd1;
			case (state)
				S_IDLE:
					if (cmd.cmd_valid)
					begin
						rw    <= cmd.cmd.header.read;
						state <= cmd.cmd.header.read ? S_READ_SELECT : S_WRITE_SELECT;
					end
				S_WRITE_SELECT:
				begin
					select      <= 128'd1 << header_q.index;
					cycle_count <= 4'd0;
					state       <= S_WRITE_HOLD;
				end
				S_WRITE_HOLD:
					if (cycle_count == 4'(`UNIBOARD_SELECT_CYCLES - 1))
					begin
						select      <= 128'd0;
						cycle_count <= 4'd0;
						state       <= S_WRITE_GAP;
					end
				S_WRITE_GAP:
					// Readback of the written register starts here
					if (cycle_count == 4'(`UNIBOARD_SELECT_GAP_CYCLES - 1))
					begin
						rw    <= 1'b1;
						state <= S_READ_SELECT;
					end
				S_READ_SELECT:
				begin
					select      <= 128'd1 << header_q.index;
					cycle_count <= 4'd0;
					state       <= S_READ_HOLD;
				end
				S_READ_HOLD:
					if (cycle_count == 4'(`UNIBOARD_SELECT_CYCLES))
					begin
						select            <= 128'd0;
						reply.reply_start <= 1'b1;
						state             <= S_REPLY;
					end
				default:
					if (reply.reply_done)
						state <= S_IDLE;
			endcase
		end
	end
endmodule

// File: protocol/frame_receiver.sv
// Unescapes incoming frames and issues a command on a valid end byte
// Bytes that arrive while the bridge is busy are lost and close any open frame
`timescale 1ns/10ps
`include "uniboard_defines.svh"

module frame_receiver (
	input  logic       clk_12MHz,
	input  logic       reset,
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	command_if.sender  cmd
);
	logic [7:0] buffer [`UNIBOARD_BUF_DEPTH];
	logic [2:0] count;
	logic       frame_open;
	logic       escape;
	logic       accept;
	logic       is_start;
	logic       is_end;
	logic       is_esc;
	logic       open_frame;
	logic       store_byte;

	always_comb
	begin
		accept   = rx_valid && cmd.bridge_idle;
		is_start = rx_data == `UNIBOARD_START_BYTE;
		is_end   = rx_data == `UNIBOARD_END_BYTE;
		is_esc   = rx_data == `UNIBOARD_ESC_BYTE;
		// An escaped start byte is data, not a new frame
		open_frame = accept && !escape && is_start;
		store_byte = accept && frame_open && (escape || !(is_start || is_end || is_esc))
			&& count < 3'(`UNIBOARD_BUF_DEPTH);
	end

	// Header, address, then the write word with byte 2 lowest
	assign cmd.cmd = {buffer[0], buffer[1], buffer[5], buffer[4], buffer[3], buffer[2]};

	always_ff @(posedge clk_12MHz)
	begin
		if (open_frame)
		begin
			for (int i = 0; i < `UNIBOARD_BUF_DEPTH; i++)
				buffer[i] <= 8'h00;
		end
		else if (store_byte)
			buffer[count] <= rx_data;
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			frame_open    <= 1'b0;
			escape        <= 1'b0;
			count         <= 3'd0;
			cmd.cmd_valid <= 1'b0;
		end
		else
		begin
			cmd.cmd_valid <= 1'b0;
			if (rx_valid && !cmd.bridge_idle)
			begin
				frame_open <= 1'b0;
				escape     <= 1'b0;
			end
			else if (open_frame)
			begin
				frame_open <= 1'b1;
				count      <= 3'd0;
			end
			else if (accept && frame_open)
			begin
				if (escape)
					escape <= 1'b0;
				else if (is_esc)
					escape <= 1'b1;
				else if (is_end)
				begin
					// Header and address are the least a command needs
					frame_open    <= 1'b0;
					cmd.cmd_valid <= count >= 3'd2;
				end
				if (store_byte)
					count <= count + 3'd1;
			end
		end
	end
endmodule

// File: uart/uart_transmitter.sv
// 8N1 transmitter. A send pulse is only taken while busy is low
// tx_data is sampled on the cycle of the send pulse
`timescale 1ns/10ps
`include "uniboard_defines.svh"

module uart_transmitter (
	input  logic       clk_12MHz,
	input  logic       reset,
	input  logic [7:0] tx_data,
	input  logic       send,
	output logic       tx,
	output logic       busy
);
	logic [9:0]  shift_reg;
	logic [15:0] tick_count;
	logic [3:0]  bit_count;

	// Line idles high between frames
	assign tx = busy ? shift_reg[0] : 1'b1;

	// Stop bit, data LSB first, start bit at the bottom
	always_ff @(posedge clk_12MHz)
	begin
		if (send && !busy)
			shift_reg <= {1'b1, tx_data, 1'b0};
		else if (busy && tick_count == 16'd0)
			shift_reg <= {1'b1, shift_reg[9:1]};
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			busy       <= 1'b0;
			tick_count <= 16'd0;
			bit_count  <= 4'd0;
		end
		else if (!busy)
		begin
			busy       <= send;
			tick_count <= 16'(`UNIBOARD_BAUD_DIV - 1);
			bit_count  <= 4'd0;
		end
		else if (tick_count != 16'd0)
			tick_count <= tick_count - 16'd1;
		else
		begin
			tick_count <= 16'(`UNIBOARD_BAUD_DIV - 1);
			// Ten bits in all, busy drops at the end of the stop bit
			if (bit_count == 4'd9)
				busy <= 1'b0;
			else
				bit_count <= bit_count + 4'd1;
		end
	end
endmodule

// File: uart/uart_receiver.sv
// 8N1 receiver, one rx_valid pulse per byte with a high stop bit
// Bytes with a low stop bit are dropped without notice
`timescale 1ns/10ps
`include "uniboard_defines.svh"

module uart_receiver (
	input  logic       clk_12MHz,
	input  logic       reset,
	input  logic       rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t   state;
	logic [1:0]  rx_sync;
	logic [15:0] tick_count;
	logic [2:0]  bit_index;

	// Data bits arrive LSB first and shift in from the top
	always_ff @(posedge clk_12MHz)
	begin
		if (state == RX_DATA && tick_count == 16'd0)
			rx_data <= {rx_sync[1], rx_data[7:1]};
	end

	always_ff @(posedge clk_12MHz)
	begin
		if (reset)
		begin
			state      <= RX_IDLE;
			rx_sync    <= 2'b11;
			tick_count <= 16'd0;
			bit_index  <= 3'd0;
			rx_valid   <= 1'b0;
		end
		else
		begin
			rx_sync  <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE:
					if (!rx_sync[1])
					begin
						// Half a bit brings us to the middle of the start bit
						tick_count <= 16'(`UNIBOARD_BAUD_DIV / 2 - 1);
						state      <= RX_START;
					end
				RX_START:
					if (tick_count != 16'd0)
						tick_count <= tick_count - 16'd1;
					else if (rx_sync[1])
						state <= RX_IDLE;
					else
					begin
						tick_count <= 16'(`UNIBOARD_BAUD_DIV - 1);
						bit_index  <= 3'd0;
						state      <= RX_DATA;
					end
				RX_DATA:
					if (tick_count != 16'd0)
						tick_count <= tick_count - 16'd1;
					else
					begin
						tick_count <= 16'(`UNIBOARD_BAUD_DIV - 1);
						bit_index  <= bit_index + 3'd1;
						if (bit_index == 3'd7)
							state <= RX_STOP;
					end
				default:
					if (tick_count != 16'd0)
						tick_count <= tick_count - 16'd1;
					else
					begin
						rx_valid <= rx_sync[1];
						state    <= RX_IDLE;
					end
			endcase
		end
	end
endmodule

// File: common/protocol_ifs.sv
// Links between the frame receiver, the bus sequencer and the reply framer
// cmd_valid and reply_start are single-cycle pulses
`timescale 1ns/10ps

interface command_if;
	logic                   cmd_valid;
	uniboard_pkg::command_t cmd;
	// High while no command or reply is in progress
	logic                   bridge_idle;

	modport sender (
		output cmd_valid,
		output cmd,
		input  bridge_idle
	);

	modport receiver (
		input  cmd_valid,
		input  cmd,
		output bridge_idle
	);
endinterface

interface reply_if;
	logic                      reply_start;
	uniboard_pkg::cmd_header_t reply_header;
	logic [7:0]                reply_addr;
	logic [31:0]               reply_data;
	// Number of data bytes in the reply, at most four
	logic [2:0]                reply_size;
	logic                      reply_done;

	modport source (
		output reply_start,
		output reply_header,
		output reply_addr,
		output reply_data,
		output reply_size,
		input  reply_done
	);

	modport sink (
		input  reply_start,
		input  reply_header,
		input  reply_addr,
		input  reply_data,
		input  reply_size,
		output reply_done
	);
endinterface

// File: common/uniboard_pkg.sv
// Command types shared by the protocol blocks
// The header is one byte with the read flag in bit 7
package uniboard_pkg;

	// Bit 7 selects a plain read, bits 6:0 index one of 128 peripherals
	typedef struct packed {
		logic       read;
		logic [6:0] index;
	} cmd_header_t;

	// A decoded command frame
	// The write word carries frame byte 2 in its low byte
	// Bytes that the host did not send read as zero
	typedef struct packed {
		cmd_header_t header;
		logic [7:0]  addr;
		logic [31:0] wdata;
	} command_t;

endpackage

// File: common/uniboard_defines.svh
// Bridge timing and framing constants. The baud divisor assumes a 12 MHz clock
// and gives 1 Mbaud at the default of 12
`ifndef UNIBOARD_DEFINES_SVH
`define UNIBOARD_DEFINES_SVH

// Clock cycles per UART bit
`define UNIBOARD_BAUD_DIV 12

// Frame marker bytes
`define UNIBOARD_START_BYTE 8'h01
`define UNIBOARD_END_BYTE 8'h17
`define UNIBOARD_ESC_BYTE 8'h1B

// Header, address and up to four write bytes
`define UNIBOARD_BUF_DEPTH 6

// Select high time on a write, and wait from select rise to read capture
`define UNIBOARD_SELECT_CYCLES 2
`define UNIBOARD_SELECT_GAP_CYCLES 2

`endif
